// File: all.f
rtl/nrf_pkg.sv
rtl/nrf_txn_if.sv
rtl/nrf_spi_txn.sv
rtl/nrf_init_seq.sv
rtl/nrf_rx_handler.sv
rtl/nrf_ctrl_top.sv
dv/tb_nrf_ctrl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_nrf_ctrl
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/nrf_input.txt
# F n b0 .. bn-1 : expected SPI frame of n bytes, bytes in hex
# R p : receive event serving payload p, X p : receive event cut by a reset
F 2 20 0b
F 2 21 01
F 2 22 01
F 2 23 03
F 2 25 4c
F 2 26 06
F 2 27 70
F 6 30 e7 e7 e7 e7 e7
F 6 2a e7 e7 e7 e7 e7
F 2 31 01
F 1 e1
F 1 e2
R a5
R 3c
R 00
R ff
X 77
F 2 20 0b
F 2 21 01
F 2 22 01
F 2 23 03
F 2 25 4c
F 2 26 06
F 2 27 70
F 6 30 e7 e7 e7 e7 e7
F 6 2a e7 e7 e7 e7 e7
F 2 31 01
F 1 e1
F 1 e2
R c3

// File: dv/tb_nrf_ctrl.sv
// --------------------------------------------------------------------------
// Testbench for the radio controller with SPI slave model, frame monitor,
// file-driven checks and watchdog
// --------------------------------------------------------------------------
module tb_nrf_ctrl;

    import nrf_pkg::*;

    localparam int PWRUP_WAIT = 50;
    localparam int OP_FRAME   = 0;
    localparam int OP_RX      = 1;
    localparam int OP_RX_RST  = 2;

    logic  clk = 1'b0;
    logic  rst;
    logic  spi_start, spi_done, spi_hold_csn, ce, irq_n, rx_valid;
    byte_t spi_tx, spi_rx, rx_data;

    int    seed = 32310;
    int    cycle = 0;
    byte_t serve_byte;          // Payload returned behind the dummy byte
    int    slave_idx;
    int    timeout_cycles;
    int    frame_no;
    int    end_cycle;
    logic  init_complete;
    byte_t prev_cmd;

    logic  in_frame, start_ce, prev_valid;
    int    start_gap;
    byte_t cur_bytes[$];
    byte_t fr_bytes[$];
    int    fr_len[$];
    int    fr_gap[$];
    logic  fr_ce[$];
    byte_t rx_q[$];

    // Script from the data file
    int    op_kind[$];
    int    op_arg[$];
    byte_t exp_all[$];
    byte_t exp_bytes[$];

    nrf_ctrl_top #(
        .PWRUP_WAIT (PWRUP_WAIT)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .spi_start    (spi_start),
        .spi_tx       (spi_tx),
        .spi_rx       (spi_rx),
        .spi_done     (spi_done),
        .spi_hold_csn (spi_hold_csn),
        .ce           (ce),
        .irq_n        (irq_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------------------------------
    // Compare tasks
    // --------------------------------------------------------------------------
    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_frame(input byte_t got, input byte_t exp, input int idx);
        if (got !== exp) begin
            $display("ERROR at %0t: frame %0d byte %0d is %h, expected %h",
                     $time, frame_no, idx, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rx(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s (got %b, expected %b)", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_frame();
        int    n;
        int    got_len;
        int    gap;
        int    i;
        logic  ce_start;
        n = exp_bytes.size();
        while (fr_len.size() == 0) @(posedge clk);
        frame_no++;
        got_len  = fr_len.pop_front();
        gap      = fr_gap.pop_front();
        ce_start = fr_ce.pop_front();
        check_bit(got_len == n, 1'b1,
                  $sformatf("frame %0d has %0d bytes, expected %0d", frame_no, got_len, n));
        for (i = 0; i < n; i++) begin
            check_frame(fr_bytes.pop_front(), exp_bytes[i], i);
        end
        if (prev_cmd == (CMD_W_REGISTER | REG_CONFIG)) begin
            check_bit(gap >= PWRUP_WAIT, 1'b1,
                      $sformatf("power-up gap of %0d cycles after CONFIG", gap));
        end
        check_bit(ce_start, init_complete, "ce level at frame start");
        if (n == 1 && exp_bytes[0] == CMD_FLUSH_RX) init_complete = 1'b1;
        prev_cmd = exp_bytes[0];
    endtask

    task automatic run_receive(input byte_t payload);
        byte_t got;
        serve_byte = payload;
        @(posedge clk);
        #1;
        check_bit(ce, 1'b1, "ce before a receive event");
        irq_n = 1'b0;
        exp_bytes.delete();
        exp_bytes.push_back(CMD_R_RX_PAYLOAD);
        exp_bytes.push_back(DUMMY_BYTE);
        expect_frame();
        while (rx_q.size() == 0) @(posedge clk);
        got = rx_q.pop_front();
        check_rx(got, payload, "rx_data");
        check_bit(in_frame || fr_len.size() != 0, 1'b0,
                  "status clear frame began before rx_valid");
        @(posedge clk);
        #1;
        irq_n = 1'b1;
        exp_bytes.delete();
        exp_bytes.push_back(CMD_W_REGISTER | REG_STATUS);
        exp_bytes.push_back(STATUS_CLEAR_RX_DR);
        expect_frame();
        check_bit(rx_q.size() == 0, 1'b1, "extra rx_valid pulse for one interrupt");
    endtask

    task automatic run_reset_receive(input byte_t payload);
        serve_byte = payload;
        @(posedge clk);
        #1;
        irq_n = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!spi_hold_csn);
        rst   = 1'b1;  // Payload frame in flight
        irq_n = 1'b1;
        @(negedge clk);
        check_bit(spi_start, 1'b0, "spi_start in reset");
        check_bit(spi_hold_csn, 1'b0, "spi_hold_csn in reset");
        check_bit(ce, 1'b0, "ce in reset");
        check_bit(rx_valid, 1'b0, "rx_valid in reset");
        check_rx(spi_tx, 8'h00, "spi_tx in reset");
        check_rx(rx_data, 8'h00, "rx_data in reset");
        repeat (4) @(posedge clk);
        #1;
        rst           = 1'b0;
        init_complete = 1'b0;
        prev_cmd      = '0;
    endtask

    task automatic load_script();
        int    fd;
        int    code;
        int    n;
        int    v;
        int    i;
        int    bytes;
        int    cfg_runs;
        string tok;
        string line;
        bytes    = 0;
        cfg_runs = 0;
        fd = $fopen("dv/nrf_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/nrf_input.txt");
            stop_run();
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code == 1) begin
                    if (tok == "#") begin
                        code = $fgets(line, fd);
                    end else if (tok == "F") begin
                        code = $fscanf(fd, "%d", n);
                        op_kind.push_back(OP_FRAME);
                        op_arg.push_back(n);
                        for (i = 0; i < n; i++) begin
                            code = $fscanf(fd, "%h", v);
                            exp_all.push_back(byte_t'(v));
                        end
                        if (n > 0 && exp_all[exp_all.size() - n] == (CMD_W_REGISTER | REG_CONFIG))
                            cfg_runs++;
                        bytes += n;
                    end else if (tok == "R" || tok == "X") begin
                        code = $fscanf(fd, "%h", v);
                        op_kind.push_back(tok == "R" ? OP_RX : OP_RX_RST);
                        op_arg.push_back(v);
                        bytes += (tok == "R") ? 4 : 2;
                    end else begin
                        $display("Unknown line type %s in the stimulus file", tok);
                        stop_run();
                    end
                end
            end
            $fclose(fd);
            timeout_cycles = 20 * bytes + cfg_runs * PWRUP_WAIT + 1000;
        end
    endtask

    // --------------------------------------------------------------------------
    // SPI slave model and frame monitor
    // --------------------------------------------------------------------------
    always begin : spi_slave
        int    lat;
        logic  aborted;
        byte_t reply;
        @(negedge clk);
        if (rst || !spi_hold_csn) slave_idx = 0;
        if (!rst && spi_start) begin
            lat   = 1 + (($random(seed) & 32'h7fff_ffff) % 8);
            reply = (slave_idx == 1) ? serve_byte : byte_t'($random(seed));
            slave_idx++;
            aborted = 1'b0;
            repeat (lat) begin
                @(posedge clk);
                if (rst) aborted = 1'b1;
            end
            #1;
            if (!aborted && !rst) begin
                spi_rx   = reply;
                spi_done = 1'b1;
                @(posedge clk);
                #1;
                spi_done = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        cycle++;
        if (rst) begin
            in_frame   = 1'b0;
            prev_valid = 1'b0;
            end_cycle  = cycle;
            cur_bytes.delete();  // Partial frame is dropped
        end else begin
            if (spi_start) begin
                check_bit(spi_hold_csn, 1'b1, "spi_start outside chip select");
                if (!in_frame) begin
                    in_frame  = 1'b1;
                    start_gap = cycle - end_cycle;
                    start_ce  = ce;
                end
                cur_bytes.push_back(spi_tx);
            end
            if (in_frame && !spi_hold_csn) begin
                fr_len.push_back(cur_bytes.size());
                fr_gap.push_back(start_gap);
                fr_ce.push_back(start_ce);
                while (cur_bytes.size() > 0) fr_bytes.push_back(cur_bytes.pop_front());
                in_frame  = 1'b0;
                end_cycle = cycle;
            end
            check_bit(prev_valid && rx_valid, 1'b0, "rx_valid high for more than one cycle");
            if (rx_valid) rx_q.push_back(rx_data);
            prev_valid = rx_valid;
        end
    end

    initial begin : watchdog
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        stop_run();
    end

    // --------------------------------------------------------------------------
    // Main sequence
    // --------------------------------------------------------------------------
    initial begin : main
        int pos;
        int k;
        int i;
        rst           = 1'b1;
        irq_n         = 1'b1;
        spi_rx        = '0;
        spi_done      = 1'b0;
        serve_byte    = '0;
        init_complete = 1'b0;
        prev_cmd      = '0;
        frame_no      = 0;
        pos           = 0;
        load_script();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (k = 0; k < op_kind.size(); k++) begin
            case (op_kind[k])
                OP_FRAME: begin
                    exp_bytes.delete();
                    for (i = 0; i < op_arg[k]; i++) exp_bytes.push_back(exp_all[pos + i]);
                    pos += op_arg[k];
                    expect_frame();
                end
                OP_RX:   run_receive(byte_t'(op_arg[k]));
                default: run_reset_receive(byte_t'(op_arg[k]));
            endcase
        end
        repeat (50) @(posedge clk);  // Catch stray frames
        if (fr_len.size() == 0 && rx_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Unexpected frames or rx_valid pulses after the last event");
            stop_run();
        end
    end

endmodule

// File: rtl/nrf_ctrl_top.sv
// --------------------------------------------------------------------------
// Radio controller top level
// --------------------------------------------------------------------------
module nrf_ctrl_top #(
    parameter int PWRUP_WAIT = nrf_pkg::PWRUP_WAIT_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,

    // Byte-wide SPI master
    output logic       spi_start,
    output logic [7:0] spi_tx,
    input  logic [7:0] spi_rx,
    input  logic       spi_done,
    output logic       spi_hold_csn,

    // Radio pins
    output logic       ce,
    input  logic       irq_n,

    // Received payload
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic init_done;

    nrf_txn_if init_txn ();
    nrf_txn_if rx_txn ();

    nrf_spi_txn spi_txn0 (
        .clk          (clk),
        .rst          (rst),
        .init_txn     (init_txn.engine),
        .rx_txn       (rx_txn.engine),
        .spi_start    (spi_start),
        .spi_tx       (spi_tx),
        .spi_rx       (spi_rx),
        .spi_done     (spi_done),
        .spi_hold_csn (spi_hold_csn)
    );

    nrf_init_seq #(
        .PWRUP_WAIT (PWRUP_WAIT)
    ) init_seq0 (
        .clk       (clk),
        .rst       (rst),
        .txn       (init_txn.client),
        .init_done (init_done)
    );

    nrf_rx_handler rx_handler0 (
        .clk       (clk),
        .rst       (rst),
        .init_done (init_done),
        .irq_n     (irq_n),
        .txn       (rx_txn.client),
        .ce        (ce),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

endmodule

// File: rtl/nrf_rx_handler.sv
// --------------------------------------------------------------------------
// Receive handler with IRQ synchroniser, CE drive, payload read and RX_DR clear
// --------------------------------------------------------------------------
module nrf_rx_handler (
    input  logic           clk,
    input  logic           rst,
    input  logic           init_done,
    input  logic           irq_n,
    nrf_txn_if.client      txn,
    output logic           ce,
    output nrf_pkg::byte_t rx_data,
    output logic           rx_valid
);

    import nrf_pkg::*;

    rx_state_e state;
    logic      irq_s1;
    logic      irq_s2;
    logic      irq_sync;

    // --------------------------------------------------------------------------
    // Three-stage synchroniser, idle high
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_s1   <= 1'b1;
            irq_s2   <= 1'b1;
            irq_sync <= 1'b1;
        end else begin
            irq_s1   <= irq_n;
            irq_s2   <= irq_s1;
            irq_sync <= irq_s2;
        end
    end

    // Receive mode as soon as configuration is complete
    assign ce = init_done;

    // --------------------------------------------------------------------------
    // Transaction requests
    // --------------------------------------------------------------------------
    assign txn.req  = (state != RX_IDLE);
    assign txn.cmd  = (state == RX_CLEAR) ? (CMD_W_REGISTER | REG_STATUS) : CMD_R_RX_PAYLOAD;
    assign txn.len  = txn_len_t'(1);  // One data byte in both frames
    assign txn.data = (state == RX_CLEAR) ? addr_t'(STATUS_CLEAR_RX_DR)
                                          : {ADDR_BYTES{DUMMY_BYTE}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RX_IDLE;
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;

            case (state)
                RX_IDLE: begin
                    if (init_done && !irq_sync) begin
                        state <= RX_READ;
                    end
                end
                RX_READ: begin
                    if (txn.done) begin
                        rx_data  <= txn.rd_byte;  // Byte clocked in behind the dummy
                        rx_valid <= 1'b1;
                        state    <= RX_CLEAR;
                    end
                end
                RX_CLEAR: begin
                    if (txn.done) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/nrf_init_seq.sv
// --------------------------------------------------------------------------
// Init sequencer over the package transaction table, with power-up wait
// --------------------------------------------------------------------------
module nrf_init_seq #(
    parameter int PWRUP_WAIT = nrf_pkg::PWRUP_WAIT_DEFAULT
) (
    input  logic      clk,
    input  logic      rst,
    nrf_txn_if.client txn,
    output logic      init_done
);

    import nrf_pkg::*;

    init_state_e                         state;
    init_idx_t                           idx;       // Current table entry
    logic [$clog2(PWRUP_WAIT + 1)-1:0]   wait_cnt;

    // --------------------------------------------------------------------------
    // Request fields straight from the table
    // --------------------------------------------------------------------------
    assign txn.req  = (state == INIT_SEND);
    assign txn.cmd  = init_cmd[idx];
    assign txn.len  = init_len[idx];
    assign txn.data = init_data[idx];

    assign init_done = (state == INIT_READY);

    // --------------------------------------------------------------------------
    // Entry stepping
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= INIT_SEND;
            idx      <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                INIT_SEND: begin
                    if (txn.done) begin
                        if (idx == '0) begin
                            // CONFIG written, radio needs time to power up
                            state    <= INIT_PWRUP;
                            wait_cnt <= '0;
                            idx      <= idx + 1'b1;
                        end else if (idx == init_idx_t'(INIT_TXN_COUNT - 1)) begin
                            state <= INIT_READY;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                INIT_PWRUP: begin
                    if (wait_cnt == $bits(wait_cnt)'(PWRUP_WAIT - 1)) begin
                        state <= INIT_SEND;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                INIT_READY: begin
                    state <= INIT_READY;  // Held until reset
                end
                default: state <= INIT_SEND;
            endcase
        end
    end

endmodule

// File: rtl/nrf_spi_txn.sv
// --------------------------------------------------------------------------
// Byte engine for framed SPI transactions, arbitrating two clients
// --------------------------------------------------------------------------
module nrf_spi_txn (
    input  logic           clk,
    input  logic           rst,
    nrf_txn_if.engine      init_txn,
    nrf_txn_if.engine      rx_txn,
    output logic           spi_start,
    output nrf_pkg::byte_t spi_tx,
    input  nrf_pkg::byte_t spi_rx,
    input  logic           spi_done,
    output logic           spi_hold_csn
);

    import nrf_pkg::*;

    txn_state_e state;
    logic       sel_rx;      // Client owning the current frame
    logic       done_q;
    txn_len_t   byte_cnt;    // Data bytes still to send
    addr_t      shift_q;
    byte_t      rd_q;
    logic       grant_init;
    logic       grant_rx;
    logic       last_byte;

    // Hold off a grant in the done cycle, the old request is still up
    assign grant_init = (state == TXN_IDLE) && !done_q && init_txn.req;
    assign grant_rx   = (state == TXN_IDLE) && !done_q && !init_txn.req && rx_txn.req;

    assign last_byte = (state != TXN_IDLE) && spi_done && (byte_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= TXN_IDLE;
            sel_rx       <= 1'b0;
            done_q       <= 1'b0;
            byte_cnt     <= '0;
            spi_start    <= 1'b0;
            spi_tx       <= '0;
            spi_hold_csn <= 1'b0;
        end else begin
            spi_start <= 1'b0;
            done_q    <= 1'b0;

            case (state)
                TXN_IDLE: begin
                    if (grant_init || grant_rx) begin
                        sel_rx       <= grant_rx;
                        spi_tx       <= grant_rx ? rx_txn.cmd : init_txn.cmd;
                        byte_cnt     <= grant_rx ? rx_txn.len : init_txn.len;
                        spi_start    <= 1'b1;
                        spi_hold_csn <= 1'b1;
                        state        <= TXN_CMD;
                    end
                end
                TXN_CMD, TXN_DATA: begin
                    if (spi_done) begin
                        if (byte_cnt != '0) begin
                            spi_tx    <= shift_q[BYTE_W-1:0];
                            spi_start <= 1'b1;
                            byte_cnt  <= byte_cnt - 1'b1;
                            state     <= TXN_DATA;
                        end else begin
                            spi_hold_csn <= 1'b0;  // End of frame
                            done_q       <= 1'b1;
                            state        <= TXN_IDLE;
                        end
                    end
                end
                default: state <= TXN_IDLE;
            endcase
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (grant_init || grant_rx) begin
            shift_q <= grant_rx ? rx_txn.data : init_txn.data;
        end else if (state != TXN_IDLE && spi_done && byte_cnt != '0) begin
            shift_q <= shift_q >> BYTE_W;
        end

        if (last_byte) begin
            rd_q <= spi_rx;
        end
    end

    assign init_txn.done    = done_q && !sel_rx;
    assign rx_txn.done      = done_q && sel_rx;
    assign init_txn.rd_byte = rd_q;
    assign rx_txn.rd_byte   = rd_q;

endmodule

// File: rtl/nrf_txn_if.sv
// --------------------------------------------------------------------------
// One SPI transaction request and its completion
// --------------------------------------------------------------------------
interface nrf_txn_if;

    import nrf_pkg::*;

    logic     req;
    byte_t    cmd;
    txn_len_t len;      // Data bytes after the command
    addr_t    data;     // Sent LSB first
    logic     done;     // One-cycle pulse at frame end
    byte_t    rd_byte;  // Byte read on the last byte of the frame

    modport client (
        output req,
        output cmd,
        output len,
        output data,
        input  done,
        input  rd_byte
    );

    modport engine (
        input  req,
        input  cmd,
        input  len,
        input  data,
        output done,
        output rd_byte
    );

endinterface

// File: rtl/nrf_pkg.sv
// --------------------------------------------------------------------------
// Shared widths, types, register map, command bytes, init transaction table
// and state encodings for the radio controller
// --------------------------------------------------------------------------
package nrf_pkg;

    localparam int BYTE_W         = 8;
    localparam int ADDR_BYTES     = 5;
    localparam int MAX_DATA_BYTES = 5;

    typedef logic [BYTE_W-1:0]                    byte_t;
    typedef logic [ADDR_BYTES*BYTE_W-1:0]         addr_t;
    typedef logic [$clog2(MAX_DATA_BYTES+1)-1:0]  txn_len_t;

    // --------------------------------------------------------------------------
    // Commands and register addresses
    // --------------------------------------------------------------------------
    localparam byte_t CMD_W_REGISTER   = 8'h20;
    localparam byte_t CMD_R_RX_PAYLOAD = 8'h61;
    localparam byte_t CMD_FLUSH_TX     = 8'he1;
    localparam byte_t CMD_FLUSH_RX     = 8'he2;
    localparam byte_t DUMMY_BYTE       = 8'hff;

    localparam byte_t REG_CONFIG     = 8'h00;
    localparam byte_t REG_EN_AA      = 8'h01;
    localparam byte_t REG_EN_RXADDR  = 8'h02;
    localparam byte_t REG_SETUP_AW   = 8'h03;
    localparam byte_t REG_RF_CH      = 8'h05;
    localparam byte_t REG_RF_SETUP   = 8'h06;
    localparam byte_t REG_STATUS     = 8'h07;
    localparam byte_t REG_RX_ADDR_P0 = 8'h0a;
    localparam byte_t REG_TX_ADDR    = 8'h10;
    localparam byte_t REG_RX_PW_P0   = 8'h11;

    // Register values
    localparam byte_t CFG_CONFIG         = 8'h0b;  // PWR_UP, EN_CRC, PRIM_RX
    localparam byte_t CFG_EN_AA          = 8'h01;
    localparam byte_t CFG_EN_RXADDR      = 8'h01;
    localparam byte_t CFG_AW_5BYTE       = 8'h03;
    localparam byte_t RF_CHANNEL         = 8'h4c;  // Channel 76
    localparam byte_t CFG_RF_SETUP       = 8'h06;  // 1 Mbps, 0 dBm
    localparam byte_t STATUS_CLEAR_ALL   = 8'h70;
    localparam byte_t STATUS_CLEAR_RX_DR = 8'h40;
    localparam byte_t RX_PAYLOAD_LEN     = 8'h01;

    localparam addr_t TX_ADDR = 40'he7e7e7e7e7;
    localparam addr_t RX_ADDR = 40'he7e7e7e7e7;

    localparam int PWRUP_WAIT_DEFAULT = 200_000;  // 2 ms at 100 MHz

    // --------------------------------------------------------------------------
    // Init transaction table, one entry per frame
    // --------------------------------------------------------------------------
    localparam int INIT_TXN_COUNT = 12;

    typedef logic [$clog2(INIT_TXN_COUNT)-1:0] init_idx_t;

    localparam byte_t init_cmd [INIT_TXN_COUNT] = '{
        CMD_W_REGISTER | REG_CONFIG,    CMD_W_REGISTER | REG_EN_AA,
        CMD_W_REGISTER | REG_EN_RXADDR, CMD_W_REGISTER | REG_SETUP_AW,
        CMD_W_REGISTER | REG_RF_CH,     CMD_W_REGISTER | REG_RF_SETUP,
        CMD_W_REGISTER | REG_STATUS,    CMD_W_REGISTER | REG_TX_ADDR,
        CMD_W_REGISTER | REG_RX_ADDR_P0, CMD_W_REGISTER | REG_RX_PW_P0,
        CMD_FLUSH_TX,                   CMD_FLUSH_RX
    };

    localparam txn_len_t init_len [INIT_TXN_COUNT] = '{
        3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd5, 3'd5, 3'd1, 3'd0, 3'd0
    };

    localparam addr_t init_data [INIT_TXN_COUNT] = '{
        addr_t'(CFG_CONFIG),       addr_t'(CFG_EN_AA),
        addr_t'(CFG_EN_RXADDR),    addr_t'(CFG_AW_5BYTE),
        addr_t'(RF_CHANNEL),       addr_t'(CFG_RF_SETUP),
        addr_t'(STATUS_CLEAR_ALL), TX_ADDR,
        RX_ADDR,                   addr_t'(RX_PAYLOAD_LEN),
        addr_t'(0),                addr_t'(0)
    };

    typedef enum logic [1:0] {INIT_SEND, INIT_PWRUP, INIT_READY} init_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_READ, RX_CLEAR} rx_state_e;
    typedef enum logic [1:0] {TXN_IDLE, TXN_CMD, TXN_DATA} txn_state_e;

endpackage
